//--- rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// Data path and address width
`define XLEN_BITS 32

// Memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// Host byte-address map
`define HOST_IMEM_BASE 32'h0000_0000
`define HOST_DMEM_BASE 32'h0000_1000

`endif

//--- rvCorePkg.sv
`include "rvCore_macros.svh"

package rvCorePkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL,
        PASSB                                       // LUI passes the immediate through
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
    } immKindE;

    // Which memory a host address lands in
    typedef enum logic {
        REGION_IMEM = 1'b0,
        REGION_DMEM = 1'b1
    } hostRegionE;

    // Wishbone classic request from the host
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`XLEN_BITS-1:0] adr;
        logic [`XLEN_BITS-1:0] dat;
    } wbSel;

    typedef struct packed {
        logic                  ack;
        logic [`XLEN_BITS-1:0] dat;
    } wbResp;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrcImm;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       branch;
        logic       branchNe;                       // Take branch on nonzero compare
        logic       jump;
        logic       linkPc;                         // Write PC+4 to rd
        aluOpE      aluOp;
        immKindE    immKind;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrlBundle;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module instrDecoder import rvCorePkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  run,
    input  logic [`XLEN_BITS-1:0] instr,
    output ctrlBundle             ctrl,
    output logic                  halted,
    output logic                  advance
);

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       isEcall;

    assign opcode   = opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign isEcall  = (opcode == SYSTEM) && (funct3 == 3'b000) && (instr[31:20] == 12'h000);

    assign advance = run && !halted;                // One instruction retires per edge

    always_comb begin
        ctrl         = '0;                          // Unknown opcodes fall out as no-ops
        ctrl.aluOp   = ADD;
        ctrl.immKind = IMM_I;
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.rd      = instr[11:7];
        case (opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7b5 ? SUB : ADD;
                    3'b001:  ctrl.aluOp = SLL;
                    3'b010:  ctrl.aluOp = SLT;
                    3'b100:  ctrl.aluOp = XOR;
                    3'b101:  ctrl.aluOp = SRL;
                    3'b110:  ctrl.aluOp = OR;
                    3'b111:  ctrl.aluOp = AND;
                    default: ctrl.aluOp = ADD;
                endcase
            end
            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (funct3)
                    3'b010:  ctrl.aluOp = SLT;
                    3'b100:  ctrl.aluOp = XOR;
                    3'b110:  ctrl.aluOp = OR;
                    3'b111:  ctrl.aluOp = AND;
                    default: ctrl.aluOp = ADD;  // ADDI
                endcase
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.immKind   = IMM_S;
            end
            BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = funct3[0];          // BNE has funct3 001
                ctrl.aluOp    = SUB;
                ctrl.immKind  = IMM_B;
            end
            JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.linkPc   = 1'b1;
                ctrl.immKind  = IMM_J;
            end
            LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = PASSB;
                ctrl.immKind   = IMM_U;
            end
            default: ;                              // SYSTEM only halts
        endcase
    end

    // Set by a retiring ECALL, cleared once run drops
    always_ff @(posedge CLK) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (!run) begin
            halted <= 1'b0;
        end else if (advance && isEcall) begin
            halted <= 1'b1;
        end
    end

    assert property (@(posedge CLK) disable iff (rst)
        !(ctrl.memWrite && (ctrl.regWrite || ctrl.memRead)));

    // Nothing retires after the ECALL
    assert property (@(posedge CLK) disable iff (rst)
        (advance && isEcall) |=> (halted && !advance));

endmodule

//--- immGen.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module immGen import rvCorePkg::*; (
    input  logic [`XLEN_BITS-1:0] instr,
    input  immKindE               immKind,
    output logic [`XLEN_BITS-1:0] imm
);

    logic sign;

    assign sign = instr[31];                        // Sign bit sits at 31 in every format

    always_comb begin
        case (immKind)
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                // Offset is in halfwords so bit 0 is always clear
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_U:   imm = {instr[31:12], 12'h000};
            default: imm = {{20{sign}}, instr[31:20]};  // I-type
        endcase
    end

endmodule

//--- aluUnit.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module aluUnit import rvCorePkg::*; (
    input  logic [`XLEN_BITS-1:0] opA,
    input  logic [`XLEN_BITS-1:0] opB,
    input  aluOpE                 aluOp,
    output logic [`XLEN_BITS-1:0] result,
    output logic                  zero,
    output logic                  lessThan
);

    logic [4:0] shamt;

    assign shamt    = opB[4:0];                     // Only the low five bits shift
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (aluOp)
            ADD:     result = opA + opB;
            SUB:     result = opA - opB;
            AND:     result = opA & opB;
            OR:      result = opA | opB;
            XOR:     result = opA ^ opB;
            SLT:     result = {{(`XLEN_BITS-1){1'b0}}, lessThan};
            SLL:     result = opA << shamt;
            SRL:     result = opA >> shamt;         // Logical, zero fill
            PASSB:   result = opB;
            default: result = opA + opB;
        endcase
    end

    // Branches compare through SUB
    assign zero = (result == '0);

endmodule

//--- regFile.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module regFile (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic                  wrEn,
    input  logic [`XLEN_BITS-1:0] wrData,
    output logic [`XLEN_BITS-1:0] rd1Data,
    output logic [`XLEN_BITS-1:0] rd2Data
);

    logic [`XLEN_BITS-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != 5'd0)) begin
            regs[rd] <= wrData;                     // x0 never written
        end
    end

    assign rd1Data = regs[rs1];
    assign rd2Data = regs[rs2];

    // A write aimed at x0 leaves it zero
    assert property (@(posedge CLK) disable iff (rst)
        (wrEn && (rd == 5'd0)) |=> (regs[0] == '0));

endmodule

//--- progCounter.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module progCounter import rvCorePkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  run,
    input  logic                  advance,
    input  ctrlBundle             ctrl,
    input  logic [`XLEN_BITS-1:0] imm,
    input  logic                  zero,
    output logic [`XLEN_BITS-1:0] pc,
    output logic [`XLEN_BITS-1:0] pcPlus4
);

    logic [`XLEN_BITS-1:0] target;
    logic [`XLEN_BITS-1:0] nextPc;
    logic                  takeBranch;

    assign pcPlus4    = pc + 32'd4;
    assign target     = pc + imm;                   // Shared by branch and JAL
    assign takeBranch = ctrl.branch && (zero != ctrl.branchNe);

    always_comb begin
        if (ctrl.jump || takeBranch) begin
            nextPc = target;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;                               // Restart always begins at 0
        end else if (advance) begin
            pc <= nextPc;
        end
    end

endmodule

//--- memSystem.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module memSystem import rvCorePkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  run,
    input  logic                  advance,
    input  logic [`XLEN_BITS-1:0] pc,
    output logic [`XLEN_BITS-1:0] instr,
    input  logic [`XLEN_BITS-1:0] dataAddr,
    input  logic [`XLEN_BITS-1:0] storeData,
    input  logic                  memWrite,
    output logic [`XLEN_BITS-1:0] loadData,
    input  wbSel                  hostReq,
    output wbResp                 hostResp
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN_BITS-1:0] imem [`IMEM_WORDS];
    logic [`XLEN_BITS-1:0] dmem [`DMEM_WORDS];

    logic [`XLEN_BITS-1:0] imemOff;
    logic [`XLEN_BITS-1:0] dmemOff;
    logic [IMEM_AW-1:0]    hostImemIdx;
    logic [DMEM_AW-1:0]    hostDmemIdx;
    hostRegionE            hostRegion;
    logic                  hostHit;                 // New request to serve this edge
    logic                  ackReg;
    logic [`XLEN_BITS-1:0] respDat;

    // Core side, word addressed
    assign instr    = imem[pc[IMEM_AW+1:2]];
    assign loadData = dmem[dataAddr[DMEM_AW+1:2]];

    assign hostRegion  = (hostReq.adr >= `HOST_DMEM_BASE) ? REGION_DMEM : REGION_IMEM;
    assign imemOff     = hostReq.adr - `HOST_IMEM_BASE;
    assign dmemOff     = hostReq.adr - `HOST_DMEM_BASE;
    assign hostImemIdx = imemOff[IMEM_AW+1:2];
    assign hostDmemIdx = dmemOff[DMEM_AW+1:2];

    // Only while stopped, and not again in the ack cycle
    assign hostHit = hostReq.cyc && hostReq.stb && !run && !ackReg;

    always_ff @(posedge CLK) begin
        if (rst) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= hostHit;                      // Exactly one cycle per request
        end
    end

    always_ff @(posedge CLK) begin
        if (advance && memWrite) begin
            dmem[dataAddr[DMEM_AW+1:2]] <= storeData;
        end else if (hostHit && hostReq.we && (hostRegion == REGION_DMEM)) begin
            dmem[hostDmemIdx] <= hostReq.dat;
        end
        if (hostHit && hostReq.we && (hostRegion == REGION_IMEM)) begin
            imem[hostImemIdx] <= hostReq.dat;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge CLK) begin
        if (hostHit) begin
            respDat <= (hostRegion == REGION_DMEM) ? dmem[hostDmemIdx] : imem[hostImemIdx];
        end
    end

    assign hostResp.ack = ackReg;
    assign hostResp.dat = respDat;

    // The host is locked out while the core runs
    assert property (@(posedge CLK) disable iff (rst)
        (hostReq.cyc && hostReq.stb && run) |=> !hostResp.ack);

endmodule

//--- singleCycleCore.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module singleCycleCore import rvCorePkg::*; (
    input  logic  CLK,
    input  logic  rst,
    input  logic  run,
    input  wbSel  hostReq,
    output wbResp hostResp,
    output logic  halted
);

    ctrlBundle             ctrl;
    logic                  advance;
    logic [`XLEN_BITS-1:0] instr;
    logic [`XLEN_BITS-1:0] pc;
    logic [`XLEN_BITS-1:0] pcPlus4;
    logic [`XLEN_BITS-1:0] imm;
    logic [`XLEN_BITS-1:0] rd1Data;
    logic [`XLEN_BITS-1:0] rd2Data;
    logic [`XLEN_BITS-1:0] opB;
    logic [`XLEN_BITS-1:0] aluResult;
    logic                  zero;
    logic [`XLEN_BITS-1:0] loadData;
    logic [`XLEN_BITS-1:0] wbData;

    assign opB = ctrl.aluSrcImm ? imm : rd2Data;

    // Write-back select
    assign wbData = ctrl.linkPc   ? pcPlus4  :
                    ctrl.memToReg ? loadData : aluResult;

    instrDecoder decoder (
        .CLK(CLK), .rst(rst), .run(run),
        .instr(instr), .ctrl(ctrl),
        .halted(halted), .advance(advance)
    );

    immGen immUnit (.instr(instr), .immKind(ctrl.immKind), .imm(imm));

    aluUnit alu (
        .opA(rd1Data), .opB(opB), .aluOp(ctrl.aluOp),
        .result(aluResult), .zero(zero),
        .lessThan()                                 // Consumed by SLT inside the ALU
    );

    regFile regs (
        .CLK(CLK), .rst(rst),
        .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
        .wrEn(ctrl.regWrite && advance), .wrData(wbData),
        .rd1Data(rd1Data), .rd2Data(rd2Data)
    );

    progCounter pcUnit (
        .CLK(CLK), .rst(rst), .run(run), .advance(advance),
        .ctrl(ctrl), .imm(imm), .zero(zero),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    memSystem mem (
        .CLK(CLK), .rst(rst), .run(run), .advance(advance),
        .pc(pc), .instr(instr),
        .dataAddr(aluResult), .storeData(rd2Data), .memWrite(ctrl.memWrite),
        .loadData(loadData),
        .hostReq(hostReq), .hostResp(hostResp)
    );

endmodule

//--- tb_singleCycleCore.sv
`timescale 1ns/1ns
`include "rvCore_macros.svh"

module tb_singleCycleCore import rvCorePkg::*; ();

    localparam int          WB_TIMEOUT  = 20;
    localparam int          RUN_TIMEOUT = 500;
    localparam logic [31:0] ECALL       = 32'h0000_0073;
    localparam logic [31:0] OPC_OPIMM   = 32'h13;
    localparam logic [31:0] OPC_LOAD    = 32'h03;

    logic  CLK = 1'b0;
    logic  rst;
    logic  run;
    wbSel  hostReq;
    wbResp hostResp;
    logic  halted;

    integer      seed = 91689;
    int          testErrs;
    int          passCount;
    int          failCount;
    logic [31:0] prog [$];                          // Program image with word 0 at address 0
    logic [31:0] expVals [$];
    string       opNames [$];

    singleCycleCore UUT (
        .CLK(CLK), .rst(rst), .run(run),
        .hostReq(hostReq), .hostResp(hostResp), .halted(halted)
    );

    always #5 CLK = ~CLK;

    // Instruction encoders
    function automatic logic [31:0] encR(input logic [31:0] f7, input logic [31:0] f3,
                                         input logic [31:0] rd, input logic [31:0] rs1,
                                         input logic [31:0] rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encI(input logic [31:0] opc, input logic [31:0] f3,
                                         input logic [31:0] rd, input logic [31:0] rs1,
                                         input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] encS(input logic [31:0] rs2, input logic [31:0] rs1,
                                         input logic [31:0] off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [31:0] f3, input logic [31:0] rs1,
                                         input logic [31:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [31:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
    endfunction

    // LUI taking the upper 20 bits of val
    function automatic logic [31:0] encU(input logic [31:0] rd, input logic [31:0] val);
        return {val[31:12], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] signedLess(input logic [31:0] x, input logic [31:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    // LUI plus ADDI with the upper part rounded for the signed low 12 bits
    function automatic void emitConst(input logic [31:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(encU(rd, upper));
        prog.push_back(encI(OPC_OPIMM, 0, rd, rd, value));
    endfunction

    // Op into x3, then store x3 to the next result slot
    function automatic void emitOpStore(input logic [31:0] word, input logic [31:0] expected,
                                        input string name);
        prog.push_back(word);
        prog.push_back(encS(3, 0, 4 * expVals.size()));
        expVals.push_back(expected);
        opNames.push_back(name);
    endfunction

    task automatic wbCycle(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output bit ok);
        wbSel req;
        int   waitCount;
        req       = '0;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = addr;
        req.dat   = wdata;
        waitCount = 0;
        ok        = 1'b0;
        rdata     = '0;
        @(posedge CLK);
        hostReq <= req;
        while (!ok && waitCount < WB_TIMEOUT) begin
            @(negedge CLK);                         // Ack and data settled by now
            waitCount++;
            if (hostResp.ack) begin
                ok    = 1'b1;
                rdata = hostResp.dat;
            end
        end
        @(posedge CLK);
        hostReq <= '0;
    endtask

    task automatic wbWrite(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        bit          ok;
        wbCycle(1'b1, addr, data, rdata, ok);
        if (!ok) begin
            $display("Host write to 0x%08h got no acknowledge before the timeout", addr);
            testErrs++;
        end
    endtask

    task automatic wbRead(input logic [31:0] addr, output logic [31:0] data, output bit ok);
        wbCycle(1'b0, addr, '0, data, ok);
    endtask

    task automatic checkWord(input string name, input logic [31:0] coreAddr,
                             input logic [31:0] exp);
        logic [31:0] got;
        bit          ok;
        wbRead(`HOST_DMEM_BASE + coreAddr, got, ok);
        if (!ok) begin
            $display("Host read of %s got no acknowledge before the timeout", name);
            testErrs++;
        end else if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            testErrs++;
        end
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            wbWrite(`HOST_IMEM_BASE + 4 * i, prog[i]);
        end
    endtask

    task automatic runUntilHalt(input int holdCycles);
        int waitCount;
        waitCount = 0;
        @(posedge CLK);
        run <= 1'b1;
        do begin
            @(negedge CLK);
            waitCount++;
        end while (!halted && waitCount < RUN_TIMEOUT);
        if (!halted) begin
            $display("Core did not halt within %0d cycles", RUN_TIMEOUT);
            testErrs++;
        end else begin
            for (int i = 0; i < holdCycles; i++) begin
                @(negedge CLK);
                if (!halted) begin
                    $display("Halted dropped while run was still high");
                    testErrs++;
                end
            end
        end
        @(posedge CLK);
        run <= 1'b0;
    endtask

    task automatic finishTest(input string name);
        if (testErrs == 0) begin
            $display("PASS  %s", name);
            passCount++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, testErrs);
            failCount++;
        end
        testErrs = 0;
    endtask

    task automatic testHostAccess();
        logic [31:0] vals [8];
        logic [31:0] rdata;
        bit          ok;
        prog.delete();
        // Keeps the core parked during the run-high probe
        prog.push_back(ECALL);
        loadProgram();
        for (int i = 0; i < 8; i++) begin
            vals[i] = $random(seed);
            wbWrite(`HOST_DMEM_BASE + 256 + 4 * i, vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            checkWord($sformatf("dmem[%0d]", 64 + i), 256 + 4 * i, vals[i]);
        end
        wbRead(`HOST_IMEM_BASE, rdata, ok);
        if (!ok) begin
            $display("Host read of imem[0] got no acknowledge before the timeout");
            testErrs++;
        end else if (rdata !== ECALL) begin
            $display("[ERROR] imem[0]: got 0x%08h, expected 0x%08h", rdata, ECALL);
            testErrs++;
        end
        @(posedge CLK);
        run <= 1'b1;
        wbRead(`HOST_DMEM_BASE + 256, rdata, ok);
        if (ok) begin
            $display("Host read was acknowledged while the core was running");
            testErrs++;
        end
        @(posedge CLK);
        run <= 1'b0;
        finishTest("host access");
    endtask

    task automatic testAluOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immRaw;
        logic [31:0] imm;
        a      = $random(seed);
        b      = $random(seed);
        immRaw = $random(seed);
        imm    = {{20{immRaw[11]}}, immRaw[11:0]};
        prog.delete();
        expVals.delete();
        opNames.delete();
        emitConst(1, a);
        emitConst(2, b);
        emitOpStore(encR(0, 0, 3, 1, 2), a + b, "ADD");
        emitOpStore(encR(32, 0, 3, 1, 2), a - b, "SUB");
        emitOpStore(encR(0, 7, 3, 1, 2), a & b, "AND");
        emitOpStore(encR(0, 6, 3, 1, 2), a | b, "OR");
        emitOpStore(encR(0, 4, 3, 1, 2), a ^ b, "XOR");
        emitOpStore(encR(0, 2, 3, 1, 2), signedLess(a, b), "SLT");
        emitOpStore(encR(0, 1, 3, 1, 2), a << b[4:0], "SLL");
        emitOpStore(encR(0, 5, 3, 1, 2), a >> b[4:0], "SRL");
        emitOpStore(encI(OPC_OPIMM, 0, 3, 1, imm), a + imm, "ADDI");
        emitOpStore(encI(OPC_OPIMM, 7, 3, 1, imm), a & imm, "ANDI");
        emitOpStore(encI(OPC_OPIMM, 6, 3, 1, imm), a | imm, "ORI");
        emitOpStore(encI(OPC_OPIMM, 4, 3, 1, imm), a ^ imm, "XORI");
        emitOpStore(encI(OPC_OPIMM, 2, 3, 1, imm), signedLess(a, imm), "SLTI");
        prog.push_back(ECALL);
        loadProgram();
        runUntilHalt(0);
        foreach (expVals[i]) begin
            checkWord($sformatf("%s result", opNames[i]), 4 * i, expVals[i]);
        end
        finishTest("arithmetic and logic");
    endtask

    task automatic testLoadStore();
        logic [31:0] v0;
        logic [31:0] v1;
        v0 = $random(seed);
        v1 = $random(seed);
        wbWrite(`HOST_DMEM_BASE + 320, v0);
        wbWrite(`HOST_DMEM_BASE + 324, v1);
        wbWrite(`HOST_DMEM_BASE + 336, 32'hFFFF_FFFF);  // Must become zero
        prog.delete();
        prog.push_back(encI(OPC_LOAD, 2, 5, 0, 320));
        prog.push_back(encI(OPC_LOAD, 2, 6, 0, 324));
        prog.push_back(encS(6, 0, 328));            // Swapped order
        prog.push_back(encS(5, 0, 332));
        prog.push_back(encI(OPC_OPIMM, 0, 0, 5, 0));
        prog.push_back(encU(0, 32'hABCD_E000));
        prog.push_back(encS(0, 0, 336));
        prog.push_back(encR(0, 0, 7, 5, 6));
        prog.push_back(encS(7, 0, 340));
        prog.push_back(ECALL);
        loadProgram();
        runUntilHalt(0);
        checkWord("stored x6", 328, v1);
        checkWord("stored x5", 332, v0);
        checkWord("stored x0", 336, 32'h0);
        checkWord("sum of loads", 340, v0 + v1);
        finishTest("loads, stores and x0");
    endtask

    task automatic testBranches();
        int loopN;
        loopN = ($random(seed) & 32'h7) + 1;
        wbWrite(`HOST_DMEM_BASE + 384, 32'h0);
        wbWrite(`HOST_DMEM_BASE + 388, 32'h0);
        wbWrite(`HOST_DMEM_BASE + 392, 32'h0);
        prog.delete();
        prog.push_back(encI(OPC_OPIMM, 0, 1, 0, loopN));
        prog.push_back(encI(OPC_OPIMM, 0, 2, 0, 0));
        prog.push_back(encI(OPC_OPIMM, 0, 2, 2, 1));   // Loop body at 8
        prog.push_back(encI(OPC_OPIMM, 0, 1, 1, -1));
        prog.push_back(encB(1, 1, 0, -8));             // BNE back to 8
        prog.push_back(encS(2, 0, 384));
        prog.push_back(encI(OPC_OPIMM, 0, 4, 0, 32'h55));
        prog.push_back(encB(0, 1, 0, 8));              // Taken BEQ
        prog.push_back(encI(OPC_OPIMM, 0, 4, 0, 32'h66));
        prog.push_back(encS(4, 0, 388));
        prog.push_back(encB(0, 2, 0, 8));              // Not taken
        prog.push_back(encI(OPC_OPIMM, 0, 6, 0, 32'h77));
        prog.push_back(encS(6, 0, 392));
        prog.push_back(ECALL);
        loadProgram();
        runUntilHalt(0);
        checkWord("loop count", 384, loopN);
        checkWord("BEQ skip marker", 388, 32'h55);
        checkWord("BEQ fall-through marker", 392, 32'h77);
        finishTest("branches");
    endtask

    task automatic testJal();
        logic [31:0] jalAddr;
        jalAddr = 32'd4;
        wbWrite(`HOST_DMEM_BASE + 448, 32'hA5A5_A5A5);
        wbWrite(`HOST_DMEM_BASE + 452, 32'h0);
        prog.delete();
        prog.push_back(encI(OPC_OPIMM, 0, 3, 0, 32'h11));
        prog.push_back(encJ(1, 8));                 // Skips the next store
        prog.push_back(encS(3, 0, 448));
        prog.push_back(encS(1, 0, 452));
        prog.push_back(ECALL);
        loadProgram();
        runUntilHalt(0);
        checkWord("link register", 452, jalAddr + 4);
        checkWord("skipped word", 448, 32'hA5A5_A5A5);
        finishTest("JAL");
    endtask

    task automatic testHaltRestart();
        wbWrite(`HOST_DMEM_BASE + 512, 32'h0);
        wbWrite(`HOST_DMEM_BASE + 516, 32'hDEAD_BEEF);
        prog.delete();
        prog.push_back(encI(OPC_OPIMM, 0, 5, 0, 32'h7F));
        prog.push_back(encI(OPC_LOAD, 2, 1, 0, 512));
        prog.push_back(encI(OPC_OPIMM, 0, 1, 1, 1));
        prog.push_back(encS(1, 0, 512));
        prog.push_back(ECALL);
        prog.push_back(encS(5, 0, 516));            // Past the ECALL so it never retires
        prog.push_back(encS(5, 0, 512));
        loadProgram();
        runUntilHalt(8);
        checkWord("counter after first run", 512, 32'd1);
        checkWord("word after ECALL", 516, 32'hDEAD_BEEF);
        runUntilHalt(2);
        checkWord("counter after restart", 512, 32'd2);
        checkWord("word after ECALL on restart", 516, 32'hDEAD_BEEF);
        finishTest("halt and restart");
    endtask

    initial begin
        rst      <= 1'b1;
        run      <= 1'b0;
        hostReq  <= '0;
        testErrs  = 0;
        passCount = 0;
        failCount = 0;
        repeat (10) @(posedge CLK);
        rst <= 1'b0;
        testHostAccess();
        testAluOps();
        testLoadStore();
        testBranches();
        testJal();
        testHaltRestart();
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- singleCycleCore.f
+incdir+.
rvCorePkg.sv
instrDecoder.sv
immGen.sv
aluUnit.sv
regFile.sv
progCounter.sv
memSystem.sv
singleCycleCore.sv
tb_singleCycleCore.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f singleCycleCore.f \
    --top-module tb_singleCycleCore -o simCore || exit 1
simOut="$(./obj_dir/simCore)"
echo "$simOut"
echo "$simOut" | grep -q "All tests passed" && exit 0 || exit 1
